// ==== include/dmm_cfg.svh ====
// voltmeter control fpga configuration
`ifndef DMM_CFG_SVH
`define DMM_CFG_SVH

//////////////////////////////////////////////////////////////////////
// widths

`define DMM_DATA_W        32      // one register word
`define DMM_ADDR_W        8       // spi address byte, msb is the write flag
`define DMM_CNT_W         24      // precharge and aperture clk counts
`define DMM_FRAME_BITS    40      // flag + 7 bit address + data word

//////////////////////////////////////////////////////////////////////
// register map

`define DMM_REG_MODE      8'h07   // output mode select
`define DMM_REG_DIRECT    8'h08   // direct pin control
`define DMM_REG_STATUS    8'h09   // read only
`define DMM_REG_PRECHARGE 8'h0A
`define DMM_REG_AZ_LO     8'h0B   // azmux code for the lo sample
`define DMM_REG_AZ_HI     8'h0C   // azmux code for the hi sample
`define DMM_REG_PC_HI     8'h0D   // precharge switches during hi sample
`define DMM_REG_APERTURE  8'h0E

//////////////////////////////////////////////////////////////////////
// status word, msb first: pad, hw flags, magic

`define DMM_MAGIC         8'hAA
`define DMM_STAT_FLAGS_W  4
`define DMM_STAT_PAD_W    20

`endif

// ==== design/dmm_pkg.sv ====
// voltmeter control shared types
`include "dmm_cfg.svh"

package dmm_pkg;

  // output mode, unlisted codes fall back to all low
  typedef enum logic [2:0] {
    MODE_DIRECT  = 3'd0,
    MODE_LO      = 3'd1,
    MODE_HI      = 3'd2,
    MODE_PATTERN = 3'd3,
    MODE_AZ      = 3'd5
  } mode_e;

  // auto-zero sequence
  typedef enum logic [1:0] {
    AZ_IDLE,
    AZ_PRECHARGE,
    AZ_SAMPLE_HI,
    AZ_SAMPLE_LO
  } az_state_e;

  // pin vector, order matches the board header
  typedef struct packed {
    logic       meas_complete;
    logic [3:0] azmux;
    logic [1:0] pc_sw;          // precharge switches
    logic [7:0] monitor;        // scope header
    logic [3:0] leds;
  } out_pins_t;

  // sequencer and adc parameters from the register bank
  typedef struct packed {
    logic [`DMM_CNT_W-1:0] precharge;
    logic [`DMM_CNT_W-1:0] aperture;
    logic [3:0]            azmux_lo;
    logic [3:0]            azmux_hi;
    logic [1:0]            pc_hi;
  } az_params_t;

  typedef struct packed {
    az_state_e  state;
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic       led;            // toggles per completed hi/lo pair
  } az_status_t;

endpackage

// ==== design/spi_register_set.sv ====
// spi slave register bank
`timescale 1ns/100ps
`include "dmm_cfg.svh"

module spi_register_set (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          sck_i,
  input  logic                          ss_i,        // active low
  input  logic                          sdi_i,
  input  logic [`DMM_STAT_FLAGS_W-1:0]  hw_flags_i,
  output logic                          sdo_o,
  output dmm_pkg::mode_e                mode_o,
  output logic [`DMM_DATA_W-1:0]        direct_o,
  output dmm_pkg::az_params_t           az_params_o
);
  import dmm_pkg::*;

  localparam int unsigned DATA_W = `DMM_DATA_W;
  localparam int unsigned ADDR_W = `DMM_ADDR_W;
  localparam int unsigned FRAME_W = `DMM_FRAME_BITS;
  localparam int unsigned BCNT_W = $clog2(FRAME_W + 1);
  localparam logic [BCNT_W-1:0] ADDR_LAST = BCNT_W'(ADDR_W - 1);   // 8th rising edge
  localparam logic [BCNT_W-1:0] FRAME_LAST = BCNT_W'(FRAME_W - 1);
  localparam logic [BCNT_W-1:0] FRAME_END = BCNT_W'(FRAME_W);

  logic [1:0]              sck_s;
  logic [1:0]              ss_s;
  logic [1:0]              sdi_s;
  logic                    sck_d;
  logic                    ss_idle;
  logic                    sdi_b;
  logic                    sck_rise;
  logic                    sck_fall;
  logic [BCNT_W-1:0]       bit_cnt;
  logic [FRAME_W-2:0]      rx_shift;     // all frame bits but the last
  logic [DATA_W-1:0]       tx_shift;
  logic                    sdo_q;
  logic                    wr_pend;
  logic [ADDR_W-1:0]       wr_addr_q;
  logic [DATA_W-1:0]       wr_data_q;
  logic [ADDR_W-1:0]       rd_addr;
  logic [DATA_W-1:0]       rd_word;
  logic [DATA_W-1:0]       status_word;
  logic [DATA_W-1:0]       reg_mode;
  logic [DATA_W-1:0]       reg_direct;
  logic [DATA_W-1:0]       reg_precharge;
  logic [DATA_W-1:0]       reg_az_lo;
  logic [DATA_W-1:0]       reg_az_hi;
  logic [DATA_W-1:0]       reg_pc_hi;
  logic [DATA_W-1:0]       reg_aperture;

  //////////////////////////////////////////////////////////////////////
  // pin synchronisers and sck edges

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sck_s <= '0;
      ss_s  <= '1;                  // deselected
      sdi_s <= '0;
      sck_d <= 1'b0;
    end else begin
      sck_s <= {sck_s[0], sck_i};
      ss_s  <= {ss_s[0], ss_i};
      sdi_s <= {sdi_s[0], sdi_i};
      sck_d <= sck_s[1];
    end
  end

  assign ss_idle  = ss_s[1];
  assign sdi_b    = sdi_s[1];
  assign sck_rise = sck_s[1] & ~sck_d;
  assign sck_fall = ~sck_s[1] & sck_d;

  //////////////////////////////////////////////////////////////////////
  // frame counter and shifters

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bit_cnt  <= '0;
      tx_shift <= '0;
      sdo_q    <= 1'b0;
      wr_pend  <= 1'b0;
    end else if (ss_idle) begin     // also drops a cut frame
      bit_cnt  <= '0;
      tx_shift <= '0;
      sdo_q    <= 1'b0;
      wr_pend  <= 1'b0;
    end else begin
      wr_pend <= 1'b0;
      if (sck_rise && bit_cnt != FRAME_END) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == ADDR_LAST)
          tx_shift <= rd_word;      // readback of the addressed reg
        if (bit_cnt == FRAME_LAST)
          wr_pend <= rx_shift[FRAME_W-2];   // write flag, first bit in
      end else if (sck_fall) begin
        sdo_q    <= tx_shift[DATA_W-1];
        tx_shift <= {tx_shift[DATA_W-2:0], 1'b0};
      end
    end
  end

  // payload side, no reset
  always_ff @(posedge clk_i) begin
    if (sck_rise && !ss_idle)
      rx_shift <= {rx_shift[FRAME_W-3:0], sdi_b};
    if (sck_rise && !ss_idle && bit_cnt == FRAME_LAST) begin
      wr_addr_q <= {1'b0, rx_shift[FRAME_W-3:DATA_W-1]};
      wr_data_q <= {rx_shift[DATA_W-2:0], sdi_b};
    end
  end

  assign sdo_o = sdo_q & ~ss_i;     // quiet while deselected

  //////////////////////////////////////////////////////////////////////
  // register bank

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reg_mode      <= '0;
      reg_direct    <= '0;
      reg_precharge <= '0;
      reg_az_lo     <= '0;
      reg_az_hi     <= '0;
      reg_pc_hi     <= '0;
      reg_aperture  <= '0;
    end else if (wr_pend && !ss_idle) begin
      case (wr_addr_q)
        `DMM_REG_MODE:      reg_mode      <= wr_data_q;
        `DMM_REG_DIRECT:    reg_direct    <= wr_data_q;
        `DMM_REG_PRECHARGE: reg_precharge <= wr_data_q;
        `DMM_REG_AZ_LO:     reg_az_lo     <= wr_data_q;
        `DMM_REG_AZ_HI:     reg_az_hi     <= wr_data_q;
        `DMM_REG_PC_HI:     reg_pc_hi     <= wr_data_q;
        `DMM_REG_APERTURE:  reg_aperture  <= wr_data_q;
        default: ;                  // status and holes
      endcase
    end
  end

  assign status_word = {{`DMM_STAT_PAD_W{1'b0}}, hw_flags_i, `DMM_MAGIC};

  // address byte as it completes, flag bit masked off
  assign rd_addr = {1'b0, rx_shift[ADDR_W-3:0], sdi_b};

  always_comb begin
    case (rd_addr)
      `DMM_REG_MODE:      rd_word = reg_mode;
      `DMM_REG_DIRECT:    rd_word = reg_direct;
      `DMM_REG_STATUS:    rd_word = status_word;
      `DMM_REG_PRECHARGE: rd_word = reg_precharge;
      `DMM_REG_AZ_LO:     rd_word = reg_az_lo;
      `DMM_REG_AZ_HI:     rd_word = reg_az_hi;
      `DMM_REG_PC_HI:     rd_word = reg_pc_hi;
      `DMM_REG_APERTURE:  rd_word = reg_aperture;
      default:            rd_word = '0;
    endcase
  end

  assign mode_o   = mode_e'(reg_mode[$bits(mode_e)-1:0]);
  assign direct_o = reg_direct;
  assign az_params_o = '{
    precharge: reg_precharge[`DMM_CNT_W-1:0],
    aperture:  reg_aperture[`DMM_CNT_W-1:0],
    azmux_lo:  reg_az_lo[3:0],
    azmux_hi:  reg_az_hi[3:0],
    pc_hi:     reg_pc_hi[1:0]
  };

  // registers only move inside a selected frame
  a_idle_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    ss_idle |=> $stable({reg_mode, reg_direct, reg_precharge, reg_az_lo,
                         reg_az_hi, reg_pc_hi, reg_aperture}));

endmodule

// ==== design/adc_mock.sv ====
// mocked adc aperture timer
`timescale 1ns/100ps
`include "dmm_cfg.svh"

module adc_mock (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   adc_run_i,     // high while measuring
  input  logic [`DMM_CNT_W-1:0]  aperture_i,
  output logic                   measure_valid_o,
  output logic [5:0]             monitor_o
);

  logic [`DMM_CNT_W-1:0] ap_cnt;   // clks into the aperture
  logic                  done_q;   // one valid per run

  //////////////////////////////////////////////////////////////////////
  // aperture count

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ap_cnt          <= '0;
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end else if (!adc_run_i) begin
      // held in reset between samples
      ap_cnt          <= '0;
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;
      if (!done_q) begin
        if (ap_cnt == aperture_i) begin
          measure_valid_o <= 1'b1;  // aperture+1 clks after run rose
          done_q          <= 1'b1;
        end else begin
          ap_cnt <= ap_cnt + 1'b1;
        end
      end
    end
  end

  assign monitor_o = ap_cnt[5:0];   // low bits to the scope header

  // single cycle pulse
  a_valid_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    measure_valid_o |=> !measure_valid_o);

endmodule

// ==== design/az_sequencer.sv ====
// auto-zero acquisition sequencer
`timescale 1ns/100ps
`include "dmm_cfg.svh"

module az_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 enable_i,         // mode is az
  input  logic                 trigger_i,        // internal trigger level
  input  logic                 measure_valid_i,  // from the adc
  input  dmm_pkg::az_params_t  params_i,
  output logic                 adc_run_o,
  output dmm_pkg::az_status_t  status_o
);
  import dmm_pkg::*;

  localparam logic [`DMM_CNT_W-1:0] PC_LAST = 1;

  az_state_e             state_q;
  logic [`DMM_CNT_W-1:0] pc_cnt;    // precharge clks left
  logic                  led_q;
  logic                  active;

  assign active = enable_i & trigger_i;

  //////////////////////////////////////////////////////////////////////
  // fsm

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= AZ_IDLE;
      pc_cnt    <= '0;
      adc_run_o <= 1'b0;
      led_q     <= 1'b0;
    end else if (!active) begin
      // park, adc held off
      state_q   <= AZ_IDLE;
      adc_run_o <= 1'b0;
    end else begin
      case (state_q)
        AZ_IDLE: begin
          state_q <= AZ_PRECHARGE;
          pc_cnt  <= params_i.precharge;
        end
        AZ_PRECHARGE: begin
          if (pc_cnt <= PC_LAST) begin
            state_q   <= AZ_SAMPLE_HI;
            adc_run_o <= 1'b1;        // start hi aperture
          end else begin
            pc_cnt <= pc_cnt - 1'b1;
          end
        end
        AZ_SAMPLE_HI: begin
          if (measure_valid_i) begin
            state_q   <= AZ_SAMPLE_LO;
            adc_run_o <= 1'b0;        // one low clk rearms the adc
          end
        end
        AZ_SAMPLE_LO: begin
          if (measure_valid_i) begin
            state_q   <= AZ_PRECHARGE;
            adc_run_o <= 1'b0;
            pc_cnt    <= params_i.precharge;
            led_q     <= ~led_q;      // blink per pair
          end else begin
            adc_run_o <= 1'b1;
          end
        end
        default: state_q <= AZ_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // switch drive per state

  always_comb begin
    status_o.state = state_q;
    status_o.led   = led_q;
    status_o.azmux = '0;            // idle, mux off
    status_o.pc_sw = '0;
    case (state_q)
      AZ_PRECHARGE: status_o.azmux = params_i.azmux_hi;   // pc switches open
      AZ_SAMPLE_HI: begin
        status_o.azmux = params_i.azmux_hi;
        status_o.pc_sw = params_i.pc_hi;
      end
      AZ_SAMPLE_LO: status_o.azmux = params_i.azmux_lo;
      default: ;
    endcase
  end

  // precharge switches only close over the hi sample
  a_pc_sw_hi: assert property (@(posedge clk_i) disable iff (rst_i)
    status_o.pc_sw != '0 |-> state_q == AZ_SAMPLE_HI);

  // adc never runs outside a sample
  a_run_off: assert property (@(posedge clk_i) disable iff (rst_i)
    state_q inside {AZ_IDLE, AZ_PRECHARGE} |-> !adc_run_o);

endmodule

// ==== design/output_mode_mux.sv ====
// output pin mode selection
`timescale 1ns/100ps
`include "dmm_cfg.svh"

module output_mode_mux (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  dmm_pkg::mode_e           mode_i,
  input  logic [`DMM_DATA_W-1:0]   direct_i,
  input  dmm_pkg::az_status_t      az_status_i,
  input  logic                     measure_valid_i,
  input  logic [5:0]               adc_monitor_i,
  output dmm_pkg::out_pins_t       pins_o,
  output logic                     az_enable_o      // to the sequencer
);
  import dmm_pkg::*;

  localparam int unsigned PIN_W = $bits(out_pins_t);

  logic [PIN_W-1:0] pat_cnt;        // free running test pattern
  out_pins_t        az_pins;
  out_pins_t        pins_d;

  //////////////////////////////////////////////////////////////////////
  // test pattern

  always_ff @(posedge clk_i) begin
    if (rst_i)
      pat_cnt <= '0;
    else
      pat_cnt <= pat_cnt + 1'b1;
  end

  // az mode pin layout
  assign az_pins = '{
    meas_complete: measure_valid_i,
    azmux:         az_status_i.azmux,
    pc_sw:         az_status_i.pc_sw,
    monitor:       {adc_monitor_i, az_status_i.state},
    leds:          {3'b000, az_status_i.led}
  };

  assign az_enable_o = (mode_i == MODE_AZ);

  always_comb begin
    case (mode_i)
      MODE_DIRECT:  pins_d = out_pins_t'(direct_i[PIN_W-1:0]);
      MODE_LO:      pins_d = '0;
      MODE_HI:      pins_d = '1;
      MODE_PATTERN: pins_d = out_pins_t'(pat_cnt);
      MODE_AZ:      pins_d = az_pins;
      default:      pins_d = '0;    // unused codes, all low
    endcase
  end

  // output register, one clk behind the source
  always_ff @(posedge clk_i) begin
    if (rst_i)
      pins_o <= '0;
    else
      pins_o <= pins_d;
  end

endmodule

// ==== design/dmm_top.sv ====
// voltmeter control fpga top
`timescale 1ns/100ps
`include "dmm_cfg.svh"

module dmm_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          sck_i,
  input  logic                          ss_i,        // active low
  input  logic                          sdi_i,
  output logic                          sdo_o,
  input  logic [`DMM_STAT_FLAGS_W-1:0]  hw_flags_i,
  input  logic                          trigger_i,
  output dmm_pkg::out_pins_t            pins_o
);
  import dmm_pkg::*;

  mode_e                  mode;
  logic [`DMM_DATA_W-1:0] direct;
  az_params_t             az_params;
  az_status_t             az_status;
  logic                   az_enable;
  logic                   adc_run;
  logic                   measure_valid;
  logic [5:0]             adc_monitor;

  spi_register_set u_regs (
    .clk_i, .rst_i, .sck_i, .ss_i, .sdi_i, .hw_flags_i, .sdo_o,
    .mode_o      (mode),
    .direct_o    (direct),
    .az_params_o (az_params)
  );

  az_sequencer u_az_seq (
    .clk_i, .rst_i, .trigger_i,
    .enable_i        (az_enable),
    .measure_valid_i (measure_valid),
    .params_i        (az_params),
    .adc_run_o       (adc_run),
    .status_o        (az_status)
  );

  adc_mock u_adc (
    .clk_i, .rst_i,
    .adc_run_i       (adc_run),
    .aperture_i      (az_params.aperture),
    .measure_valid_o (measure_valid),
    .monitor_o       (adc_monitor)
  );

  output_mode_mux u_mux (
    .clk_i, .rst_i, .pins_o,
    .mode_i          (mode),
    .direct_i        (direct),
    .az_status_i     (az_status),
    .measure_valid_i (measure_valid),
    .adc_monitor_i   (adc_monitor),
    .az_enable_o     (az_enable)
  );

endmodule

// ==== verif/tb_dmm.sv ====
// voltmeter control fpga testbench
`timescale 1ns/100ps
`include "dmm_cfg.svh"

module tb_dmm;
  import dmm_pkg::*;

  localparam int FRAMES = 31;                                  // spi frames issued below
  localparam int FRAME_CLKS = 4 + `DMM_FRAME_BITS * 8 + 6;     // setup, bits, tail, gap
  localparam int SEQ_CLKS = 8 + 40 + 32 + 3 * (10 + 2 * (8 + 3)) + 30;
  localparam int TIMEOUT_CLKS = 4 * (FRAMES * FRAME_CLKS + SEQ_CLKS);

  logic        clk = 1'b0;
  logic        rst;
  logic        sck;
  logic        ss;                        // active low
  logic        sdi;
  logic        sdo;
  logic [3:0]  hw_flags;
  logic        trigger;
  out_pins_t   pins;
  logic [31:0] lfsr_q = 32'he6f0;
  logic [31:0] shadow [8'h07:8'h0E];      // shadow of the writable registers
  int          cycle_cnt = 0;

  dmm_top dut_i (
    .clk_i (clk), .rst_i (rst), .sck_i (sck), .ss_i (ss), .sdi_i (sdi), .sdo_o (sdo),
    .hw_flags_i (hw_flags), .trigger_i (trigger), .pins_o (pins)
  );

  always #20 clk = ~clk;                  // 40 ns

  //////////////////////////////////////////////////////////////////////
  // random source and failure handling

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;     // galois taps 32,22,2,1
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};           // one step per bit
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CLKS)
      stop_on_error($sformatf("Timeout, run still going after %0d cycles", cycle_cnt));
  end

  task automatic check_word(input string test, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      stop_on_error($sformatf("Mismatch %s expected %h actual %h", test, exp, act));
  endtask

  task automatic check_bit(input string test, input logic exp, input logic act);
    if (act !== exp)
      stop_on_error($sformatf("Mismatch %s expected %b actual %b", test, exp, act));
  endtask

  task automatic check_pins(input string test, input out_pins_t exp, input out_pins_t act);
    if (act !== exp)
      stop_on_error($sformatf("Mismatch %s expected %h actual %h", test, exp, act));
  endtask

  task automatic check_state(input string test, input az_state_e exp, input az_state_e act);
    if (act !== exp)
      stop_on_error($sformatf("Mismatch %s expected %s actual %s", test, exp.name(), act.name()));
  endtask

  //////////////////////////////////////////////////////////////////////
  // register model

  function automatic logic [31:0] model_read(input logic [7:0] addr);
    if (addr == `DMM_REG_STATUS)
      return {20'd0, hw_flags, `DMM_MAGIC};   // pad, flags, magic
    if (addr >= `DMM_REG_MODE && addr <= `DMM_REG_APERTURE)
      return shadow[addr];
    return '0;                                // holes read zero
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
    if (addr != `DMM_REG_STATUS && addr >= `DMM_REG_MODE && addr <= `DMM_REG_APERTURE)
      shadow[addr] = data;
  endtask

  function automatic az_state_e next_az_state(input az_state_e s);
    case (s)
      AZ_IDLE:      return AZ_PRECHARGE;
      AZ_PRECHARGE: return AZ_SAMPLE_HI;
      AZ_SAMPLE_HI: return AZ_SAMPLE_LO;
      default:      return AZ_PRECHARGE;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // spi master at 4 clks per sck half

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic spi_frame(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {wr, addr[6:0], wdata};
    rdata = '0;
    @(posedge clk);
    ss <= 1'b0;
    wait_clks(4);
    for (int i = 39; i >= 0; i--) begin
      sck <= 1'b0;                        // falling edge shifts sdo
      sdi <= frame[i];
      wait_clks(3);
      @(negedge clk);
      if (i < 32)
        rdata[i] = sdo;                   // settled just before the rise
      @(posedge clk);
      sck <= 1'b1;
      wait_clks(4);
    end
    sck <= 1'b0;
    wait_clks(2);                         // write lands while still selected
    ss <= 1'b1;
    wait_clks(4);
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    spi_frame(1'b1, addr, data, rd);
    check_word($sformatf("write frame readback %h", addr), model_read(addr), rd);
    model_write(addr, data);
  endtask

  task automatic reg_read(input logic [7:0] addr);
    logic [31:0] rd;
    spi_frame(1'b0, addr, rand_bits(32), rd);   // payload ignored on reads
    check_word($sformatf("read %h", addr), model_read(addr), rd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin : stim
    logic [31:0] word;
    logic [18:0] pat_prev;
    logic [23:0] pc_len;
    logic [23:0] ap_len;
    logic [3:0]  az_lo;
    logic [3:0]  az_hi;
    logic [1:0]  pc_hi;
    logic [3:0]  exp_mux;
    logic [1:0]  exp_pc;
    logic        led_exp;
    logic        prev_mc;
    out_pins_t   cur;
    out_pins_t   idle_pins;
    az_state_e   st;
    az_state_e   prev_st;
    int          phase_len;
    int          rounds;

    rst = 1'b1;
    sck = 1'b0;
    ss = 1'b1;
    sdi = 1'b0;
    hw_flags = '0;
    trigger = 1'b0;
    for (int a = 8'h07; a <= 8'h0E; a++)
      shadow[a] = '0;
    wait_clks(8);
    rst <= 1'b0;
    wait_clks(2);

    // quiet after reset
    @(negedge clk);
    check_pins("pins after reset", '0, pins);
    check_bit("sdo after reset", 1'b0, sdo);

    // writable registers with full words
    for (int a = 8'h07; a <= 8'h0E; a++)
      if (a != 8'h09)
        reg_write(8'(a), rand_bits(32));
    for (int a = 8'h07; a <= 8'h0E; a++)
      if (a != 8'h09)
        reg_read(8'(a));
    @(negedge clk);
    check_bit("sdo while deselected", 1'b0, sdo);

    // status is read only with flags from the pins
    @(posedge clk);
    hw_flags <= 4'(rand_bits(4));
    wait_clks(4);
    reg_write(`DMM_REG_STATUS, rand_bits(32));
    reg_read(`DMM_REG_STATUS);
    reg_write(8'h20, rand_bits(32));        // write to a hole is dropped
    reg_read(8'h20);
    reg_read(8'h00);

    // static modes
    word = rand_bits(32);
    reg_write(`DMM_REG_DIRECT, word);
    reg_write(`DMM_REG_MODE, 32'(MODE_DIRECT));
    @(negedge clk);
    check_pins("mode direct", out_pins_t'(word[18:0]), pins);
    reg_write(`DMM_REG_MODE, 32'(MODE_LO));
    @(negedge clk);
    check_pins("mode lo", '0, pins);
    reg_write(`DMM_REG_MODE, 32'(MODE_HI));
    @(negedge clk);
    check_pins("mode hi", '1, pins);
    reg_write(`DMM_REG_MODE, 32'd7);        // unused code
    @(negedge clk);
    check_pins("mode unused code", '0, pins);

    // pattern counts up by one per clk
    reg_write(`DMM_REG_MODE, 32'(MODE_PATTERN));
    @(negedge clk);
    pat_prev = pins;
    repeat (32) begin
      @(negedge clk);
      check_word("pattern step", 32'(19'(pat_prev + 19'd1)), 32'(19'(pins)));
      pat_prev = pins;
    end

    // auto-zero setup with small counts
    pc_len = 24'(3 + rand_bits(3));         // 3..10
    ap_len = 24'(1 + rand_bits(3));         // 1..8
    word = rand_bits(32);
    az_lo = word[3:0];
    reg_write(`DMM_REG_AZ_LO, word);
    word = rand_bits(32);
    az_hi = word[3:0];
    reg_write(`DMM_REG_AZ_HI, word);
    word = rand_bits(32);
    if (word[1:0] == 2'b00)
      word[1:0] = 2'b11;                    // keep the switches visible
    pc_hi = word[1:0];
    reg_write(`DMM_REG_PC_HI, word);
    reg_write(`DMM_REG_PRECHARGE, 32'(pc_len));
    reg_write(`DMM_REG_APERTURE, 32'(ap_len));
    reg_write(`DMM_REG_MODE, 32'(MODE_AZ));

    @(posedge clk);
    trigger <= 1'b1;
    prev_st = AZ_IDLE;
    prev_mc = 1'b0;
    led_exp = 1'b0;
    phase_len = 0;
    rounds = 0;
    while (rounds < 3) begin
      @(negedge clk);
      cur = pins;
      st = az_state_e'(cur.monitor[1:0]);
      if (st != prev_st) begin
        check_state("az order", next_az_state(prev_st), st);
        if (prev_st == AZ_PRECHARGE)
          check_word("precharge length", 32'(pc_len), 32'(phase_len));
        if (prev_st == AZ_SAMPLE_HI || prev_st == AZ_SAMPLE_LO) begin
          if (phase_len < ap_len + 1)
            stop_on_error("sample phase ended before aperture+1 cycles");
          check_bit("meas_complete ends sample", 1'b1, prev_mc);
        end
        if (prev_st == AZ_SAMPLE_LO) begin
          rounds++;
          led_exp = ~led_exp;               // blinks per hi/lo pair
        end
        phase_len = 0;
      end else if (st == AZ_SAMPLE_HI || st == AZ_SAMPLE_LO) begin
        check_bit("meas_complete inside sample", 1'b0, prev_mc);
      end
      phase_len++;
      case (st)
        AZ_PRECHARGE: begin
          exp_mux = az_hi;
          exp_pc = 2'b00;
        end
        AZ_SAMPLE_HI: begin
          exp_mux = az_hi;
          exp_pc = pc_hi;
        end
        AZ_SAMPLE_LO: begin
          exp_mux = az_lo;
          exp_pc = 2'b00;
        end
        default: begin
          exp_mux = 4'h0;
          exp_pc = 2'b00;
        end
      endcase
      check_word("az azmux", 32'(exp_mux), 32'(cur.azmux));
      check_word("az pc_sw", 32'(exp_pc), 32'(cur.pc_sw));
      check_word("az leds", 32'({3'b000, led_exp}), 32'(cur.leds));
      if (cur.meas_complete)
        check_word("adc monitor at valid", 32'(ap_len[5:0]), 32'(cur.monitor[7:2]));
      if (st == AZ_IDLE || st == AZ_PRECHARGE)
        check_bit("meas_complete outside sample", 1'b0, cur.meas_complete);
      prev_st = st;
      prev_mc = cur.meas_complete;
    end

    // dropping the trigger inside precharge parks the sequencer
    @(posedge clk);
    trigger <= 1'b0;
    wait_clks(4);
    idle_pins = '0;
    idle_pins.leds = {3'b000, led_exp};
    repeat (16) begin
      @(negedge clk);
      check_state("az idle state", AZ_IDLE, az_state_e'(pins.monitor[1:0]));
      check_pins("az idle pins", idle_pins, pins);
    end

    $display("Test passed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
design/dmm_pkg.sv
design/spi_register_set.sv
design/adc_mock.sv
design/az_sequencer.sv
design/output_mode_mux.sv
design/dmm_top.sv
verif/tb_dmm.sv

// ==== Bender.yml ====
package:
  name: dmm_ctrl

export_include_dirs:
  - include

sources:
  - design/dmm_pkg.sv
  - design/spi_register_set.sv
  - design/adc_mock.sv
  - design/az_sequencer.sv
  - design/output_mode_mux.sv
  - design/dmm_top.sv
  - target: test
    files:
      - verif/tb_dmm.sv
